// File: hdl/mcu_cfg.svh
//////////////////////////////
// MCU build configuration
// Memory depths, boot address, bus width
//////////////////////////////

`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// Memory depths in 32-bit words
`define MCU_IMEM_WORDS 256
`define MCU_DMEM_WORDS 256

// Byte address of the first fetch
`define MCU_BOOT_ADDR 32'h0000_0000

// OBI data and address width
`define MCU_XLEN 32

`endif

// File: hdl/mcu_pkg.sv
//////////////////////////////
// OBI request/response structs
// Accumulator core opcodes and instruction format
//////////////////////////////

`include "mcu_cfg.svh"

package mcu_pkg;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`MCU_XLEN/8-1:0] be;
        logic [`MCU_XLEN-1:0]   addr;
        logic [`MCU_XLEN-1:0]   wdata;
    } obi_req_t;

    typedef struct packed {
        logic                 gnt;
        logic                 rvalid;
        logic [`MCU_XLEN-1:0] rdata;
    } obi_resp_t;

    // Opcode lives in instruction bits [31:28]; unlisted codes execute as no-op
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,  // acc = zext(imm)
        OP_LD   = 4'h2,  // acc = mem[idx]
        OP_ST   = 4'h3,  // mem[idx] = acc
        OP_ADD  = 4'h4,  // acc = acc + mem[idx]
        OP_XOR  = 4'h5,  // acc = acc ^ mem[idx]
        OP_ADDI = 4'h6,  // acc = acc + zext(imm)
        OP_BNZ  = 4'h7,  // pc = imm word index when acc != 0
        OP_HALT = 4'hf
    } opcode_e;

    // Operand in [15:0] is an immediate or a data word index.
    // All arithmetic wraps modulo 2**32
    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] rsvd;
        logic [15:0] operand;
    } instr_t;

endpackage

// File: hdl/obi_sram.sv
//////////////////////////////
// Single-port OBI word memory
//////////////////////////////

`timescale 1ns/10ps

`include "mcu_cfg.svh"

module obi_sram
    import mcu_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  logic      clk_i,
    input  logic      arst_n_i,

    input  obi_req_t  req_i,
    output obi_resp_t resp_o
);

    localparam int AW = $clog2(WORDS);

    logic [`MCU_XLEN-1:0] mem_q [WORDS];
    logic [`MCU_XLEN-1:0] rdata_q;
    logic                 rvalid_q;
    logic [AW-1:0]        idx;

    // Word index wraps at the memory depth
    assign idx = req_i.addr[AW+1:2];

    // Always ready
    assign resp_o.gnt    = req_i.req;
    assign resp_o.rvalid = rvalid_q;
    assign resp_o.rdata  = rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (req_i.we) begin
                for (int b = 0; b < `MCU_XLEN / 8; b++) begin
                    if (req_i.be[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
                // Write response carries zero data
                rdata_q <= '0;
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) rvalid_q <= 1'b0;
        else           rvalid_q <= req_i.req;
    end

    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_o.rvalid |-> $past(req_i.req && resp_o.gnt));

endmodule

// File: hdl/obi_arbiter.sv
//////////////////////////////
// Two-master fixed-priority OBI arbiter
//////////////////////////////

`timescale 1ns/10ps

module obi_arbiter
    import mcu_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    // Port 0, highest priority
    input  obi_req_t  m0_req_i,
    output obi_resp_t m0_resp_o,

    // Port 1, served when port 0 is quiet
    input  obi_req_t  m1_req_i,
    output obi_resp_t m1_resp_o,

    // Towards the memory
    output obi_req_t  s_req_o,
    input  obi_resp_t s_resp_i
);

    logic gnt0;
    logic gnt1;
    logic owner_q;

    assign s_req_o = m0_req_i.req ? m0_req_i : m1_req_i;

    assign gnt0 = m0_req_i.req & s_resp_i.gnt;
    assign gnt1 = m1_req_i.req & ~m0_req_i.req & s_resp_i.gnt;

    // Remembers who owns the response due next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= 1'b0;
        end else if (gnt0 || gnt1) begin
            owner_q <= gnt1;
        end
    end

    always_comb begin
        m0_resp_o.gnt    = gnt0;
        m0_resp_o.rvalid = s_resp_i.rvalid & ~owner_q;
        m0_resp_o.rdata  = owner_q ? '0 : s_resp_i.rdata;

        m1_resp_o.gnt    = gnt1;
        m1_resp_o.rvalid = s_resp_i.rvalid & owner_q;
        m1_resp_o.rdata  = owner_q ? s_resp_i.rdata : '0;
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(m0_resp_o.gnt && m1_resp_o.gnt));

    // Response only to the port granted the cycle before
    a_m0_resp_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        m0_resp_o.rvalid |-> $past(m0_resp_o.gnt));

    a_m1_resp_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        m1_resp_o.rvalid |-> $past(m1_resp_o.gnt));

endmodule

// File: hdl/cpu_subsystem.sv
//////////////////////////////
// Accumulator CPU with OBI instr/data ports
//////////////////////////////

`timescale 1ns/10ps

`include "mcu_cfg.svh"

module cpu_subsystem
    import mcu_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      fetch_enable_i,

    // Instruction fetch port, read only
    output obi_req_t  core_instr_req_o,
    input  obi_resp_t core_instr_resp_i,

    // Data port
    output obi_req_t  core_data_req_o,
    input  obi_resp_t core_data_resp_i,

    output logic      core_sleep_o
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        EXEC,
        DATA,
        DATA_WAIT,
        SLEEP
    } state_e;

    state_e               state_q;
    logic [`MCU_XLEN-1:0] pc_q;
    logic [`MCU_XLEN-1:0] acc_q;
    instr_t               instr_q;

    logic                 fetch_req;
    logic                 is_store;
    logic [`MCU_XLEN-1:0] imm_ext;
    logic [`MCU_XLEN-1:0] data_addr;
    logic [`MCU_XLEN-1:0] branch_target;

    // Operand decode
    assign imm_ext       = {{(`MCU_XLEN-16){1'b0}}, instr_q.operand};
    assign data_addr     = {{(`MCU_XLEN-18){1'b0}}, instr_q.operand, 2'b00};
    assign branch_target = data_addr;
    assign is_store      = (instr_q.opcode == OP_ST);

    // Fetch starts in the same cycle fetch enable shows up
    assign fetch_req = (state_q == FETCH) || ((state_q == IDLE) && fetch_enable_i);

    always_comb begin
        core_instr_req_o.req   = fetch_req;
        core_instr_req_o.we    = 1'b0;
        core_instr_req_o.be    = '1;
        core_instr_req_o.addr  = pc_q;
        core_instr_req_o.wdata = '0;
    end

    always_comb begin
        core_data_req_o.req   = (state_q == DATA);
        core_data_req_o.we    = (state_q == DATA) && is_store;
        core_data_req_o.be    = '1;
        core_data_req_o.addr  = data_addr;
        core_data_req_o.wdata = acc_q;
    end

    assign core_sleep_o = (state_q == SLEEP);

    // Instruction register
    always_ff @(posedge clk_i) begin
        if ((state_q == FETCH_WAIT) && core_instr_resp_i.rvalid) begin
            instr_q <= instr_t'(core_instr_resp_i.rdata);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            pc_q    <= `MCU_BOOT_ADDR;
            acc_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_enable_i) begin
                        state_q <= core_instr_resp_i.gnt ? FETCH_WAIT : FETCH;
                    end
                end
                FETCH: begin
                    if (core_instr_resp_i.gnt) state_q <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (core_instr_resp_i.rvalid) state_q <= EXEC;
                end
                EXEC: begin
                    pc_q    <= pc_q + `MCU_XLEN'(4);
                    state_q <= FETCH;
                    case (instr_q.opcode)
                        OP_LDI:  acc_q <= imm_ext;
                        OP_ADDI: acc_q <= acc_q + imm_ext;
                        OP_BNZ: begin
                            if (acc_q != '0) pc_q <= branch_target;
                        end
                        OP_HALT: state_q <= SLEEP;
                        OP_LD, OP_ST, OP_ADD, OP_XOR: state_q <= DATA;
                        default: ;
                    endcase
                end
                DATA: begin
                    if (core_data_resp_i.gnt) state_q <= DATA_WAIT;
                end
                DATA_WAIT: begin
                    if (core_data_resp_i.rvalid) begin
                        state_q <= FETCH;
                        case (instr_q.opcode)
                            OP_LD:   acc_q <= core_data_resp_i.rdata;
                            OP_ADD:  acc_q <= acc_q + core_data_resp_i.rdata;
                            OP_XOR:  acc_q <= acc_q ^ core_data_resp_i.rdata;
                            default: ;
                        endcase
                    end
                end
                // Parked until the next reset
                SLEEP: ;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request must hold until the arbiter grants it
    a_instr_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_instr_req_o.req && !core_instr_resp_i.gnt |=>
            core_instr_req_o.req && $stable(core_instr_req_o.addr));

    a_data_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_data_req_o.req && !core_data_resp_i.gnt |=>
            core_data_req_o.req && $stable(core_data_req_o.addr)
            && $stable(core_data_req_o.we) && $stable(core_data_req_o.wdata));

endmodule

// File: hdl/mcu_top.sv
//////////////////////////////
// MCU top: core, arbiters, memories
//////////////////////////////

`timescale 1ns/10ps

`include "mcu_cfg.svh"

module mcu_top
    import mcu_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      fetch_enable_i,

    // Host access to instruction memory
    input  obi_req_t  ext_imem_req_i,
    output obi_resp_t ext_imem_resp_o,

    // Host access to data memory
    input  obi_req_t  ext_dmem_req_i,
    output obi_resp_t ext_dmem_resp_o,

    output logic      core_sleep_o
);

    obi_req_t  core_instr_req;
    obi_resp_t core_instr_resp;
    obi_req_t  core_data_req;
    obi_resp_t core_data_resp;

    obi_req_t  imem_req;
    obi_resp_t imem_resp;
    obi_req_t  dmem_req;
    obi_resp_t dmem_resp;

    cpu_subsystem u_cpu (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .fetch_enable_i    (fetch_enable_i),
        .core_instr_req_o  (core_instr_req),
        .core_instr_resp_i (core_instr_resp),
        .core_data_req_o   (core_data_req),
        .core_data_resp_i  (core_data_resp),
        .core_sleep_o      (core_sleep_o)
    );

    // Instruction path
    obi_arbiter u_imem_arb (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .m0_req_i  (core_instr_req),
        .m0_resp_o (core_instr_resp),
        .m1_req_i  (ext_imem_req_i),
        .m1_resp_o (ext_imem_resp_o),
        .s_req_o   (imem_req),
        .s_resp_i  (imem_resp)
    );

    obi_sram #(.WORDS(`MCU_IMEM_WORDS)) u_imem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (imem_req),
        .resp_o   (imem_resp)
    );

    // Data path
    obi_arbiter u_dmem_arb (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .m0_req_i  (core_data_req),
        .m0_resp_o (core_data_resp),
        .m1_req_i  (ext_dmem_req_i),
        .m1_resp_o (ext_dmem_resp_o),
        .s_req_o   (dmem_req),
        .s_resp_i  (dmem_resp)
    );

    obi_sram #(.WORDS(`MCU_DMEM_WORDS)) u_dmem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (dmem_req),
        .resp_o   (dmem_resp)
    );

endmodule

// File: dv/tb_mcu.sv
//////////////////////////////
// MCU testbench: OBI host tasks, reference
// model, program tests and report
//////////////////////////////

`timescale 1ns/10ps

`include "mcu_cfg.svh"

module tb_mcu
    import mcu_pkg::*;
();

    localparam int TIMEOUT     = 200;
    localparam int RUN_TIMEOUT = 5000;
    localparam int DATA_SPAN   = 80;
    localparam int TABLE_BASE  = 64;

    logic      clk;
    logic      arst_n;
    logic      fetch_enable;
    obi_req_t  ext_imem_req;
    obi_resp_t ext_imem_resp;
    obi_req_t  ext_dmem_req;
    obi_resp_t ext_dmem_resp;
    logic      core_sleep;

    integer seed = 32'ha1ef0bb7;
    int     errors;
    int     checks;
    int     test_base;
    int     tests_run;
    int     prog_len;

    // Host-side images and the model's expected data memory
    logic [31:0] prog_img [`MCU_IMEM_WORDS];
    logic [31:0] data_img [`MCU_DMEM_WORDS];
    logic [31:0] exp_img  [`MCU_DMEM_WORDS];

    mcu_top u_dut (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .fetch_enable_i  (fetch_enable),
        .ext_imem_req_i  (ext_imem_req),
        .ext_imem_resp_o (ext_imem_resp),
        .ext_dmem_req_i  (ext_dmem_req),
        .ext_dmem_resp_o (ext_dmem_resp),
        .core_sleep_o    (core_sleep)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] encode_instr(input opcode_e op, input logic [15:0] operand);
        return {op, 12'h000, operand};
    endfunction

    function automatic string port_name(input bit port);
        if (port) return "ext_dmem";
        return "ext_imem";
    endfunction

    function automatic obi_resp_t port_resp(input bit port);
        if (port) return ext_dmem_resp;
        return ext_imem_resp;
    endfunction

    task automatic drive_port(input bit port, input obi_req_t req);
        if (port) ext_dmem_req = req;
        else      ext_imem_req = req;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        fetch_enable = 1'b0;
        ext_imem_req = '0;
        ext_dmem_req = '0;
        arst_n       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    endtask

    // One OBI transfer; gnt and rvalid are sampled 1 ns after the falling edge
    task automatic obi_access(input bit port, input bit write, input int idx,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        obi_req_t  req;
        obi_resp_t resp;
        int        n;
        req.req   = 1'b1;
        req.we    = write;
        req.be    = 4'hf;
        req.addr  = idx * 4;
        req.wdata = wdata;
        @(negedge clk);
        drive_port(port, req);
        #1;
        resp = port_resp(port);
        n = 0;
        while (!resp.gnt && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            resp = port_resp(port);
            n++;
        end
        checks++;
        assert (resp.gnt) else begin
            $display("Timeout: %s was never granted for word %0d", port_name(port), idx);
            errors++;
        end
        @(negedge clk);
        drive_port(port, '0);
        #1;
        resp = port_resp(port);
        n = 0;
        while (!resp.rvalid && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            resp = port_resp(port);
            n++;
        end
        checks++;
        assert (resp.rvalid) else begin
            $display("Timeout: %s gave no response for word %0d", port_name(port), idx);
            errors++;
        end
        rdata = resp.rdata;
    endtask

    task automatic obi_write(input bit port, input int idx, input logic [31:0] wdata);
        logic [31:0] unused;
        obi_access(port, 1'b1, idx, wdata, unused);
    endtask

    task automatic obi_read(input bit port, input int idx, output logic [31:0] rdata);
        obi_access(port, 1'b0, idx, '0, rdata);
    endtask

    // Executes prog_img on a copy of data_img; returns steps to HALT, -1 if none
    function automatic int run_model(input int max_steps);
        logic [31:0] acc;
        logic [31:0] w;
        logic [31:0] imm;
        logic [3:0]  op;
        int          pc;
        int          didx;
        acc = '0;
        pc  = int'(`MCU_BOOT_ADDR >> 2);
        for (int i = 0; i < `MCU_DMEM_WORDS; i++) begin
            exp_img[i] = data_img[i];
        end
        for (int step = 0; step < max_steps; step++) begin
            w    = prog_img[pc];
            op   = w[31:28];
            imm  = {16'h0000, w[15:0]};
            didx = int'(w[15:0]) % `MCU_DMEM_WORDS;
            pc   = (pc + 1) % `MCU_IMEM_WORDS;
            case (op)
                OP_LDI:  acc = imm;
                OP_LD:   acc = exp_img[didx];
                OP_ST:   exp_img[didx] = acc;
                OP_ADD:  acc = acc + exp_img[didx];
                OP_XOR:  acc = acc ^ exp_img[didx];
                OP_ADDI: acc = acc + imm;
                OP_BNZ: begin
                    if (acc != 0) pc = int'(w[15:0]) % `MCU_IMEM_WORDS;
                end
                OP_HALT: return step + 1;
                default: ;
            endcase
        end
        return -1;
    endfunction

    function automatic void fill_data();
        for (int i = 0; i < `MCU_DMEM_WORDS; i++) begin
            data_img[i] = '0;
        end
        for (int i = 0; i < DATA_SPAN; i++) begin
            data_img[i] = $random(seed);
        end
    endfunction

    function automatic void build_arith_prog();
        logic [31:0] r;
        fill_data();
        r = $random(seed);
        prog_img[0]  = encode_instr(OP_LD, 16'd0);
        prog_img[1]  = encode_instr(OP_ADD, 16'd1);
        prog_img[2]  = encode_instr(OP_XOR, 16'd2);
        prog_img[3]  = encode_instr(OP_ADDI, r[15:0]);
        prog_img[4]  = encode_instr(OP_ST, 16'd16);
        prog_img[5]  = encode_instr(OP_ADD, 16'd3);
        prog_img[6]  = encode_instr(OP_XOR, 16'd4);
        prog_img[7]  = encode_instr(OP_ST, 16'd17);
        prog_img[8]  = encode_instr(OP_LD, 16'd5);
        prog_img[9]  = encode_instr(OP_ADDI, 16'hffff);
        prog_img[10] = encode_instr(OP_ST, 16'd18);
        prog_img[11] = encode_instr(OP_HALT, 16'd0);
        prog_len = 12;
    endfunction

    // Counter at word 20 counts up from -n to zero
    function automatic void build_loop_prog();
        int          n;
        logic [31:0] start;
        fill_data();
        n = 3 + ($random(seed) & 7);
        start = $random(seed);
        data_img[20] = 0 - n;
        data_img[23] = 32'hffff_0000;
        prog_img[0]  = encode_instr(OP_LDI, start[15:0]);
        prog_img[1]  = encode_instr(OP_ST, 16'd21);
        prog_img[2]  = encode_instr(OP_LD, 16'd21);
        prog_img[3]  = encode_instr(OP_ADDI, 16'hffff);
        prog_img[4]  = encode_instr(OP_XOR, 16'd23);
        prog_img[5]  = encode_instr(OP_ST, 16'd21);
        prog_img[6]  = encode_instr(OP_LD, 16'd20);
        prog_img[7]  = encode_instr(OP_ADDI, 16'd1);
        prog_img[8]  = encode_instr(OP_ST, 16'd20);
        prog_img[9]  = encode_instr(OP_BNZ, 16'd2);
        prog_img[10] = encode_instr(OP_HALT, 16'd0);
        prog_len = 11;
    endfunction

    task automatic load_and_start();
        int steps;
        reset_dut();
        for (int i = 0; i < DATA_SPAN; i++) begin
            obi_write(1'b1, i, data_img[i]);
        end
        for (int i = 0; i < prog_len; i++) begin
            obi_write(1'b0, i, prog_img[i]);
        end
        steps = run_model(10000);
        checks++;
        assert (steps > 0) else begin
            $display("Reference model ran the program without reaching HALT");
            errors++;
        end
        @(negedge clk);
        fetch_enable = 1'b1;
    endtask

    task automatic wait_sleep();
        int n;
        n = 0;
        while (!core_sleep && n < RUN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (core_sleep) else begin
            $display("Timeout: core_sleep_o stayed low for %0d cycles", RUN_TIMEOUT);
            errors++;
        end
    endtask

    task automatic compare_dmem();
        logic [31:0] got;
        for (int i = 0; i < DATA_SPAN; i++) begin
            obi_read(1'b1, i, got);
            check_word($sformatf("dmem[%0d]", i), got, exp_img[i]);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_base);
        end
        test_base = errors;
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] r;
        logic [31:0] words [16];
        int          reads;
        int          idx;
        arst_n       = 1'b0;
        fetch_enable = 1'b0;
        ext_imem_req = '0;
        ext_dmem_req = '0;
        errors       = 0;
        checks       = 0;
        test_base    = 0;
        tests_run    = 0;
        prog_len     = 0;

        // Core stays idle while fetch enable is low
        reset_dut();
        check_word("core_sleep_o", {31'b0, core_sleep}, 32'h0);
        obi_read(1'b0, 0, got);
        obi_read(1'b1, 0, got);
        r = $random(seed);
        // A program that would overwrite word 40 and halt if the core ran
        obi_write(1'b0, 0, encode_instr(OP_LDI, ~r[15:0]));
        obi_write(1'b0, 1, encode_instr(OP_ST, 16'd40));
        obi_write(1'b0, 2, encode_instr(OP_HALT, 16'd0));
        obi_write(1'b1, 40, r);
        repeat (50) @(negedge clk);
        obi_read(1'b1, 40, got);
        check_word("dmem[40]", got, r);
        check_word("core_sleep_o", {31'b0, core_sleep}, 32'h0);
        report_test("after reset");

        for (int i = 0; i < 16; i++) begin
            words[i] = $random(seed);
            obi_write(1'b0, 128 + i, words[i]);
        end
        for (int i = 0; i < 16; i++) begin
            obi_read(1'b0, 128 + i, got);
            check_word($sformatf("imem[%0d]", 128 + i), got, words[i]);
        end
        report_test("program load");

        build_arith_prog();
        load_and_start();
        wait_sleep();
        compare_dmem();
        report_test("arithmetic");

        build_loop_prog();
        load_and_start();
        wait_sleep();
        compare_dmem();
        report_test("loop");

        // Host reads the table while the core competes for the data port
        build_arith_prog();
        load_and_start();
        reads = 0;
        while (!core_sleep && reads < 64) begin
            idx = TABLE_BASE + reads % 16;
            obi_read(1'b1, idx, got);
            check_word($sformatf("dmem[%0d]", idx), got, data_img[idx]);
            reads++;
        end
        wait_sleep();
        compare_dmem();
        report_test("contention");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/mcu_pkg.sv
hdl/obi_sram.sv
hdl/obi_arbiter.sv
hdl/cpu_subsystem.sv
hdl/mcu_top.sv
dv/tb_mcu.sv

// File: run.sh
#!/bin/sh
# Build the MCU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_mcu -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mcu)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
